/* src/mci_pkg.sv */
/*
  Shared definitions for the management controller: bus widths, register
  offsets, AXI response codes and the enums used by the RTL blocks.
*/
package mci_pkg;

  ////////////////////
  // Bus widths
  ////////////////////

  localparam int AddrW = 12;
  localparam int DataW = 32;

  typedef logic [AddrW-1:0] addr_t;
  typedef logic [DataW-1:0] data_t;

  // AXI4-Lite response codes used by this slave
  typedef enum logic [1:0] {
    RespOkay   = 2'b00,
    RespSlvErr = 2'b10
  } axi_resp_e;

  ////////////////////
  // Register map
  ////////////////////

  typedef enum logic [AddrW-1:0] {
    RegWdtCfg            = 12'h000,  // [0] timer1_en, [1] timer2_en
    RegWdtT1Period       = 12'h004,
    RegWdtT2Period       = 12'h008,
    RegWdtRestart        = 12'h00C,  // [0] pet timer 1, [1] pet timer 2
    RegWdtStatus         = 12'h010,  // [0] t1_timeout, [1] t2_timeout, W1C
    RegHwErrFatal        = 12'h040,
    RegHwErrNonFatal     = 12'h044,
    RegHwErrFatalMask    = 12'h048,
    RegHwErrNonFatalMask = 12'h04C,
    RegFwErrFatal        = 12'h050,
    RegFwErrNonFatal     = 12'h054
  } mci_reg_e;

  // Everything from here up is decoded by the error aggregator
  localparam addr_t ErrBlockBase = 12'h040;

  // Timer 2 enable doubles as the mode select
  typedef enum logic {
    WdtCascade     = 1'b0,
    WdtIndependent = 1'b1
  } wdt_mode_e;

  typedef enum logic [1:0] {
    StIdle,
    StWrResp,
    StRdResp
  } axil_state_e;

endpackage

/* src/mci_reg_if.sv */
`timescale 1ns/1ps

/*
  Register access port between the bus slave and one register block.
  Single-cycle strobe; the block answers combinationally.
*/
interface mci_reg_if;
  import mci_pkg::*;

  // Request side
  logic  req;
  logic  we;
  addr_t addr;
  data_t wdata;

  // Response side, valid in the same cycle as req
  data_t rdata;
  logic  err;

  modport host (
    output req, we, addr, wdata,
    input  rdata, err
  );

  modport dev (
    input  req, we, addr, wdata,
    output rdata, err
  );

endinterface

/* src/mci_axil_slave.sv */
`timescale 1ns/1ps

/*
  AXI4-Lite slave of the management controller. Accepts one access at a
  time, strobes the watchdog or the error block and returns its response.
*/
module mci_axil_slave (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Write address and data channels
  input  logic               awvalid_i,
  output logic               awready_o,
  input  mci_pkg::addr_t     awaddr_i,
  input  logic               wvalid_i,
  output logic               wready_o,
  input  mci_pkg::data_t     wdata_i,
  // Write response channel
  output logic               bvalid_o,
  input  logic               bready_i,
  output mci_pkg::axi_resp_e bresp_o,
  // Read channels
  input  logic               arvalid_i,
  output logic               arready_o,
  input  mci_pkg::addr_t     araddr_i,
  output logic               rvalid_o,
  input  logic               rready_i,
  output mci_pkg::data_t     rdata_o,
  output mci_pkg::axi_resp_e rresp_o,
  // Register blocks
  mci_reg_if.host            wdt_bus,
  mci_reg_if.host            err_bus
);
  import mci_pkg::*;

  axil_state_e state_q;
  axil_state_e state_d;
  logic        wr_go;
  logic        rd_go;
  logic        acc_go;
  addr_t       acc_addr;
  logic        sel_err_blk;
  logic        blk_err;
  data_t       blk_rdata;
  axi_resp_e   resp_q;
  data_t       rdata_q;

  ////////////////////
  // Acceptance
  ////////////////////

  // Write wins when both channels present in the same cycle
  assign wr_go  = (state_q == StIdle) && awvalid_i && wvalid_i;
  assign rd_go  = (state_q == StIdle) && arvalid_i && !(awvalid_i && wvalid_i);
  assign acc_go = wr_go || rd_go;

  assign awready_o = wr_go;
  assign wready_o  = wr_go;
  assign arready_o = rd_go;

  assign acc_addr    = wr_go ? awaddr_i : araddr_i;
  assign sel_err_blk = (acc_addr >= ErrBlockBase);

  // Both blocks see the same request but only one gets the strobe
  assign wdt_bus.req   = acc_go && !sel_err_blk;
  assign wdt_bus.we    = wr_go;
  assign wdt_bus.addr  = acc_addr;
  assign wdt_bus.wdata = wdata_i;

  assign err_bus.req   = acc_go && sel_err_blk;
  assign err_bus.we    = wr_go;
  assign err_bus.addr  = acc_addr;
  assign err_bus.wdata = wdata_i;

  assign blk_err   = sel_err_blk ? err_bus.err : wdt_bus.err;
  assign blk_rdata = sel_err_blk ? err_bus.rdata : wdt_bus.rdata;

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      StIdle: begin
        if (wr_go) begin
          state_d = StWrResp;
        end else if (rd_go) begin
          state_d = StRdResp;
        end
      end
      StWrResp: begin
        if (bready_i) begin
          state_d = StIdle;
        end
      end
      StRdResp: begin
        if (rready_i) begin
          state_d = StIdle;
        end
      end
      default: state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= StIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the block answer at acceptance and zero the data on error
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_q  <= RespOkay;
      rdata_q <= '0;
    end else if (acc_go) begin
      resp_q  <= blk_err ? RespSlvErr : RespOkay;
      rdata_q <= (blk_err || wr_go) ? '0 : blk_rdata;
    end
  end

  assign bvalid_o = (state_q == StWrResp);
  assign bresp_o  = resp_q;
  assign rvalid_o = (state_q == StRdResp);
  assign rdata_o  = rdata_q;
  assign rresp_o  = resp_q;

endmodule

/* src/mci_wdt.sv */
`timescale 1ns/1ps

/*
  Dual-timer watchdog with its config, period and status registers.
  Timer 2 follows timer 1 in cascade mode or runs on its own.
*/
module mci_wdt (
  input  logic   clk_i,
  input  logic   rst_n_i,
  mci_reg_if.dev bus,
  output logic   wdt_t1_timeout_o,
  output logic   wdt_t2_timeout_o
);
  import mci_pkg::*;

  logic [1:0] cfg_q;
  data_t      period_q [2];
  data_t      count_q  [2];
  logic [1:0] timeout_q;
  wdt_mode_e  mode;
  logic       wr_en;
  logic [1:0] pet;
  logic [1:0] svc;
  logic [1:0] restart;
  logic [1:0] active;
  logic [1:0] hit;

  assign mode  = wdt_mode_e'(cfg_q[1]);
  assign wr_en = bus.req && bus.we;

  // Pets restart a count and W1C on a set flag also services it
  assign pet     = (wr_en && bus.addr == RegWdtRestart) ? bus.wdata[1:0] : 2'b00;
  assign svc     = (wr_en && bus.addr == RegWdtStatus) ? (bus.wdata[1:0] & timeout_q) : 2'b00;
  assign restart = pet | svc;

  // In cascade mode timer 2 only runs after timer 1 has expired
  assign active[0] = cfg_q[0];
  assign active[1] = (mode == WdtIndependent) || timeout_q[0];

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      hit[i] = active[i] && !timeout_q[i] && !restart[i] &&
               ((count_q[i] + 1'b1) >= period_q[i]);
    end
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_q       <= '0;
      period_q[0] <= '0;
      period_q[1] <= '0;
    end else if (wr_en) begin
      case (bus.addr)
        RegWdtCfg:      cfg_q       <= bus.wdata[1:0];
        RegWdtT1Period: period_q[0] <= bus.wdata;
        RegWdtT2Period: period_q[1] <= bus.wdata;
        default: ;
      endcase
    end
  end

  // Counters hold while their flag is set
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q[0] <= '0;
      count_q[1] <= '0;
      timeout_q  <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (restart[i] || !active[i]) begin
          count_q[i] <= '0;
        end else if (!timeout_q[i]) begin
          count_q[i] <= count_q[i] + 1'b1;
        end
      end
      timeout_q <= (timeout_q & ~svc) | hit;
    end
  end

  // Unmapped offsets flag an error on read decode
  always_comb begin
    bus.rdata = '0;
    bus.err   = 1'b0;
    case (bus.addr)
      RegWdtCfg:      bus.rdata = DataW'(cfg_q);
      RegWdtT1Period: bus.rdata = period_q[0];
      RegWdtT2Period: bus.rdata = period_q[1];
      RegWdtRestart:  bus.rdata = '0;
      RegWdtStatus:   bus.rdata = DataW'(timeout_q);
      default:        bus.err   = 1'b1;
    endcase
  end

  assign wdt_t1_timeout_o = timeout_q[0];
  assign wdt_t2_timeout_o = timeout_q[1];

endmodule

/* src/mci_error_agg.sv */
`timescale 1ns/1ps

/*
  Error aggregator. Sticky hardware error status with masks, firmware
  error codes, and the registered fatal and non-fatal summary outputs.
*/
module mci_error_agg #(
  parameter int NumHwErr = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  mci_reg_if.dev              bus,
  input  logic [NumHwErr-1:0] hw_err_fatal_i,
  input  logic [NumHwErr-1:0] hw_err_non_fatal_i,
  input  logic                wdt_t2_timeout_i,
  output logic                all_error_fatal_o,
  output logic                all_error_non_fatal_o
);
  import mci_pkg::*;

  // Top bit of the fatal set is the watchdog timer 2 source
  logic [NumHwErr:0]   fatal_sts_q;
  logic [NumHwErr-1:0] non_fatal_sts_q;
  logic [NumHwErr:0]   fatal_mask_q;
  logic [NumHwErr-1:0] non_fatal_mask_q;
  data_t               fw_fatal_q;
  data_t               fw_non_fatal_q;
  logic                wdt_t2_q;
  logic                wr_en;
  logic [NumHwErr:0]   fatal_set;
  logic [NumHwErr:0]   fatal_clr;
  logic [NumHwErr-1:0] non_fatal_clr;

  assign wr_en     = bus.req && bus.we;
  assign fatal_set = {wdt_t2_timeout_i && !wdt_t2_q, hw_err_fatal_i};

  assign fatal_clr     = (wr_en && bus.addr == RegHwErrFatal) ?
                         bus.wdata[NumHwErr:0] : '0;
  assign non_fatal_clr = (wr_en && bus.addr == RegHwErrNonFatal) ?
                         bus.wdata[NumHwErr-1:0] : '0;

  ////////////////////
  // Status and config
  ////////////////////

  // A new error wins over a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      fatal_sts_q     <= '0;
      non_fatal_sts_q <= '0;
      wdt_t2_q        <= 1'b0;
    end else begin
      fatal_sts_q     <= (fatal_sts_q & ~fatal_clr) | fatal_set;
      non_fatal_sts_q <= (non_fatal_sts_q & ~non_fatal_clr) | hw_err_non_fatal_i;
      wdt_t2_q        <= wdt_t2_timeout_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      fatal_mask_q     <= '0;
      non_fatal_mask_q <= '0;
      fw_fatal_q       <= '0;
      fw_non_fatal_q   <= '0;
    end else if (wr_en) begin
      case (bus.addr)
        RegHwErrFatalMask:    fatal_mask_q     <= bus.wdata[NumHwErr:0];
        RegHwErrNonFatalMask: non_fatal_mask_q <= bus.wdata[NumHwErr-1:0];
        RegFwErrFatal:        fw_fatal_q       <= bus.wdata;
        RegFwErrNonFatal:     fw_non_fatal_q   <= bus.wdata;
        default: ;
      endcase
    end
  end

  // A set mask bit hides its source from the summary outputs
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      all_error_fatal_o     <= 1'b0;
      all_error_non_fatal_o <= 1'b0;
    end else begin
      all_error_fatal_o     <= (|(fatal_sts_q & ~fatal_mask_q)) || (|fw_fatal_q);
      all_error_non_fatal_o <= (|(non_fatal_sts_q & ~non_fatal_mask_q)) || (|fw_non_fatal_q);
    end
  end

  always_comb begin
    bus.rdata = '0;
    bus.err   = 1'b0;
    case (bus.addr)
      RegHwErrFatal:        bus.rdata = DataW'(fatal_sts_q);
      RegHwErrNonFatal:     bus.rdata = DataW'(non_fatal_sts_q);
      RegHwErrFatalMask:    bus.rdata = DataW'(fatal_mask_q);
      RegHwErrNonFatalMask: bus.rdata = DataW'(non_fatal_mask_q);
      RegFwErrFatal:        bus.rdata = fw_fatal_q;
      RegFwErrNonFatal:     bus.rdata = fw_non_fatal_q;
      default:              bus.err   = 1'b1;
    endcase
  end

endmodule

/* src/mci_top.sv */
`timescale 1ns/1ps

/*
  Management controller top. AXI4-Lite slave in front of the
  watchdog and the error aggregator.
*/
module mci_top #(
  parameter int NumHwErr = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // AXI4-Lite slave port
  input  logic                awvalid_i,
  output logic                awready_o,
  input  mci_pkg::addr_t      awaddr_i,
  input  logic                wvalid_i,
  output logic                wready_o,
  input  mci_pkg::data_t      wdata_i,
  output logic                bvalid_o,
  input  logic                bready_i,
  output mci_pkg::axi_resp_e  bresp_o,
  input  logic                arvalid_i,
  output logic                arready_o,
  input  mci_pkg::addr_t      araddr_i,
  output logic                rvalid_o,
  input  logic                rready_i,
  output mci_pkg::data_t      rdata_o,
  output mci_pkg::axi_resp_e  rresp_o,
  // Error sources and summaries
  input  logic [NumHwErr-1:0] hw_err_fatal_i,
  input  logic [NumHwErr-1:0] hw_err_non_fatal_i,
  output logic                wdt_t1_timeout_o,
  output logic                all_error_fatal_o,
  output logic                all_error_non_fatal_o
);

  // Timer 2 expiry feeds the fatal error status
  logic wdt_t2_timeout;

  mci_reg_if wdt_bus ();
  mci_reg_if err_bus ();

  mci_axil_slave u_axil_slave (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .awaddr_i  (awaddr_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .wdata_i   (wdata_i),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .bresp_o   (bresp_o),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .araddr_i  (araddr_i),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i),
    .rdata_o   (rdata_o),
    .rresp_o   (rresp_o),
    .wdt_bus   (wdt_bus.host),
    .err_bus   (err_bus.host)
  );

  mci_wdt u_wdt (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .bus              (wdt_bus.dev),
    .wdt_t1_timeout_o (wdt_t1_timeout_o),
    .wdt_t2_timeout_o (wdt_t2_timeout)
  );

  mci_error_agg #(
    .NumHwErr (NumHwErr)
  ) u_error_agg (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .bus                   (err_bus.dev),
    .hw_err_fatal_i        (hw_err_fatal_i),
    .hw_err_non_fatal_i    (hw_err_non_fatal_i),
    .wdt_t2_timeout_i      (wdt_t2_timeout),
    .all_error_fatal_o     (all_error_fatal_o),
    .all_error_non_fatal_o (all_error_non_fatal_o)
  );

endmodule

/* verif/mci_tb_checks.svh */
/*
  Reference functions for the watchdog and the error aggregates, and the
  compare tasks used by the controller testbench.
*/
`ifndef MCI_TB_CHECKS_SVH
`define MCI_TB_CHECKS_SVH

// Any unmasked sticky bit or any nonzero firmware code raises the output
function automatic logic exp_all_fatal(data_t sts, data_t mask, data_t fw);
  return (|(sts & ~mask & FatalBits)) || (fw != '0);
endfunction

function automatic logic exp_all_non_fatal(data_t sts, data_t mask, data_t fw);
  return (|(sts & ~mask & NonFatalBits)) || (fw != '0);
endfunction

// Expected {t2, t1} flags a number of cycles after the timers start
function automatic logic [1:0] exp_wdt_status(int elapsed, int p1, int p2, logic en1,
                                              wdt_mode_e mode);
  logic [1:0] flags;
  flags[0] = en1 && (elapsed >= p1);
  if (mode == WdtIndependent) begin
    flags[1] = (elapsed >= p2);
  end else begin
    // Timer 2 only starts once timer 1 has expired
    flags[1] = flags[0] && (elapsed >= p1 + p2);
  end
  return flags;
endfunction

task automatic check_data(input string name, input data_t got, input data_t exp);
  if (got !== exp) begin
    $display("Fail %0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
    val_errs++;
  end
endtask

task automatic check_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
  if (got !== exp) begin
    $display("Fail %0t %s: got %s, expected %s", $time, name, got.name(), exp.name());
    val_errs++;
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("Fail %0t %s: got %b, expected %b", $time, name, got, exp);
    val_errs++;
  end
endtask

`endif

/* verif/mci_tb_top.sv */
`timescale 1ns/1ps

/*
  Testbench for the management controller. Drives the AXI4-Lite port and
  checks register access, both watchdog modes and the error aggregates.
*/
module mci_tb_top;
  import mci_pkg::*;

  localparam int NumHwErr      = 4;
  localparam int ClkPeriod     = 40;
  // All tests together run for well under 1500 cycles
  localparam int TimeoutCycles = 4000;
  localparam int unsigned Seed = 32'h4ea170f2;
  localparam data_t FatalBits    = data_t'((64'd1 << (NumHwErr + 1)) - 1);
  localparam data_t NonFatalBits = data_t'((64'd1 << NumHwErr) - 1);

  logic                clk;
  logic                rst_n;
  logic                awvalid;
  logic                awready;
  addr_t               awaddr;
  logic                wvalid;
  logic                wready;
  data_t               wdata;
  logic                bvalid;
  logic                bready;
  axi_resp_e           bresp;
  logic                arvalid;
  logic                arready;
  addr_t               araddr;
  logic                rvalid;
  logic                rready;
  data_t               rdata;
  axi_resp_e           rresp;
  logic [NumHwErr-1:0] hw_err_fatal;
  logic [NumHwErr-1:0] hw_err_non_fatal;
  logic                wdt_t1_timeout;
  logic                all_error_fatal;
  logic                all_error_non_fatal;

  int    val_errs = 0;
  int    proto_errs = 0;
  int    cycle_cnt = 0;
  int    accept_cycle;
  // Reference model of the error aggregator
  data_t m_fatal_sts;
  data_t m_non_fatal_sts;
  data_t m_fatal_mask;
  data_t m_non_fatal_mask;
  data_t m_fw_fatal;
  data_t m_fw_non_fatal;
  logic  t2_prev;
  logic  exp_fatal_q;
  logic  exp_non_fatal_q;

  `include "mci_tb_checks.svh"

  mci_top #(
    .NumHwErr (NumHwErr)
  ) dut_i (
    .clk_i (clk), .rst_n_i (rst_n),
    .awvalid_i (awvalid), .awready_o (awready), .awaddr_i (awaddr),
    .wvalid_i (wvalid), .wready_o (wready), .wdata_i (wdata),
    .bvalid_o (bvalid), .bready_i (bready), .bresp_o (bresp),
    .arvalid_i (arvalid), .arready_o (arready), .araddr_i (araddr),
    .rvalid_o (rvalid), .rready_i (rready), .rdata_o (rdata), .rresp_o (rresp),
    .hw_err_fatal_i (hw_err_fatal), .hw_err_non_fatal_i (hw_err_non_fatal),
    .wdt_t1_timeout_o (wdt_t1_timeout),
    .all_error_fatal_o (all_error_fatal), .all_error_non_fatal_o (all_error_non_fatal)
  );

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  ////////////////////
  // Bus tasks
  ////////////////////

  task automatic axil_write(input addr_t addr, input data_t data, output axi_resp_e resp);
    @(posedge clk);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    do begin
      @(negedge clk);
    end while (!awready);
    check_bit("wready_o", wready, 1'b1);
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge clk);
    accept_cycle = cycle_cnt;
    check_bit("bvalid_o", bvalid, 1'b1);
    resp = bresp;
  endtask

  task automatic axil_read(input addr_t addr, output data_t data, output axi_resp_e resp);
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= addr;
    do begin
      @(negedge clk);
    end while (!arready);
    @(posedge clk);
    arvalid <= 1'b0;
    @(negedge clk);
    check_bit("rvalid_o", rvalid, 1'b1);
    data = rdata;
    resp = rresp;
  endtask

  task automatic write_reg(input addr_t addr, input data_t data);
    axi_resp_e resp;
    axil_write(addr, data, resp);
    check_resp($sformatf("bresp[%03h]", addr), resp, RespOkay);
  endtask

  task automatic expect_reg(input addr_t addr, input data_t exp);
    data_t     rd;
    axi_resp_e resp;
    axil_read(addr, rd, resp);
    check_resp($sformatf("rresp[%03h]", addr), resp, RespOkay);
    check_data($sformatf("rdata[%03h]", addr), rd, exp);
  endtask

  task automatic wait_until(input int cycle);
    while (cycle_cnt < cycle) begin
      @(negedge clk);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  ////////////////////
  // Aggregate checker
  ////////////////////

  // Inputs seen at a falling edge land in status at the next rising edge
  always @(negedge clk) begin : agg_model
    logic t2_now;
    if (!rst_n) begin
      m_fatal_sts = '0;
      m_non_fatal_sts = '0;
      m_fatal_mask = '0;
      m_non_fatal_mask = '0;
      m_fw_fatal = '0;
      m_fw_non_fatal = '0;
      t2_prev = 1'b0;
      exp_fatal_q = 1'b0;
      exp_non_fatal_q = 1'b0;
    end else begin
      check_bit("all_error_fatal_o", all_error_fatal, exp_fatal_q);
      check_bit("all_error_non_fatal_o", all_error_non_fatal, exp_non_fatal_q);
      exp_fatal_q = exp_all_fatal(m_fatal_sts, m_fatal_mask, m_fw_fatal);
      exp_non_fatal_q = exp_all_non_fatal(m_non_fatal_sts, m_non_fatal_mask, m_fw_non_fatal);
      t2_now = dut_i.wdt_t2_timeout;
      if (awready) begin
        case (awaddr)
          RegHwErrFatal:        m_fatal_sts = m_fatal_sts & ~(wdata & FatalBits);
          RegHwErrNonFatal:     m_non_fatal_sts = m_non_fatal_sts & ~(wdata & NonFatalBits);
          RegHwErrFatalMask:    m_fatal_mask = wdata & FatalBits;
          RegHwErrNonFatalMask: m_non_fatal_mask = wdata & NonFatalBits;
          RegFwErrFatal:        m_fw_fatal = wdata;
          RegFwErrNonFatal:     m_fw_non_fatal = wdata;
          default: ;
        endcase
      end
      // Timer 2 sets the top fatal bit on its rising edge only
      m_fatal_sts = m_fatal_sts | data_t'({t2_now && !t2_prev, hw_err_fatal});
      m_non_fatal_sts = m_non_fatal_sts | data_t'(hw_err_non_fatal);
      t2_prev = t2_now;
    end
  end

  initial begin : watchdog
    repeat (TimeoutCycles) @(posedge clk);
    $display("Simulation timed out after %0d cycles", TimeoutCycles);
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin : main_seq
    data_t      rd;
    axi_resp_e  resp;
    logic [1:0] ws;
    int         hold;
    int         c0;
    void'($urandom(Seed));
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    bready = 1'b1;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b1;
    hw_err_fatal = '0;
    hw_err_non_fatal = '0;
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // Register access with random data
    for (int i = 0; i < 3; i++) begin
      rd = $urandom();
      write_reg(RegWdtT1Period, rd);
      expect_reg(RegWdtT1Period, rd);
      rd = $urandom();
      write_reg(RegWdtT2Period, rd);
      expect_reg(RegWdtT2Period, rd);
      rd = $urandom();
      write_reg(RegHwErrFatalMask, rd);
      expect_reg(RegHwErrFatalMask, rd & FatalBits);
      rd = $urandom();
      write_reg(RegHwErrNonFatalMask, rd);
      expect_reg(RegHwErrNonFatalMask, rd & NonFatalBits);
      rd = $urandom();
      write_reg(RegFwErrFatal, rd);
      expect_reg(RegFwErrFatal, rd);
      rd = $urandom();
      write_reg(RegFwErrNonFatal, rd);
      expect_reg(RegFwErrNonFatal, rd);
    end
    axil_read(12'h020, rd, resp);
    check_resp("rresp[020]", resp, RespSlvErr);
    check_data("rdata[020]", rd, '0);
    axil_write(12'h020, 32'hFFFF_FFFF, resp);
    check_resp("bresp[020]", resp, RespSlvErr);
    axil_read(12'h058, rd, resp);
    check_resp("rresp[058]", resp, RespSlvErr);

    // Write response held back while a second write waits
    @(posedge clk);
    bready <= 1'b0;
    axil_write(RegWdtT1Period, 32'd111, resp);
    @(posedge clk);
    awvalid <= 1'b1;
    awaddr  <= RegWdtT2Period;
    wvalid  <= 1'b1;
    wdata   <= 32'd222;
    hold = 2 + int'($urandom() % 6);
    repeat (hold) begin
      @(negedge clk);
      if (!bvalid || awready || wready) begin
        $display("Write response dropped or new write taken while bready low at %0t", $time);
        proto_errs++;
      end
    end
    @(posedge clk);
    bready <= 1'b1;
    write_reg(RegWdtT2Period, 32'd222);
    expect_reg(RegWdtT1Period, 32'd111);
    expect_reg(RegWdtT2Period, 32'd222);
    write_reg(RegHwErrFatalMask, '0);
    write_reg(RegHwErrNonFatalMask, '0);
    write_reg(RegFwErrFatal, '0);
    write_reg(RegFwErrNonFatal, '0);

    // Cascade watchdog
    write_reg(RegWdtT1Period, 32'd20);
    write_reg(RegWdtT2Period, 32'd30);
    write_reg(RegWdtCfg, 32'h1);
    c0 = accept_cycle;
    wait_until(c0 + 15);
    ws = exp_wdt_status(15, 20, 30, 1'b1, WdtCascade);
    check_bit("wdt_t1_timeout_o", wdt_t1_timeout, ws[0]);
    wait_until(c0 + 25);
    ws = exp_wdt_status(25, 20, 30, 1'b1, WdtCascade);
    check_bit("wdt_t1_timeout_o", wdt_t1_timeout, ws[0]);
    wait_until(c0 + 60);
    ws = exp_wdt_status(60, 20, 30, 1'b1, WdtCascade);
    expect_reg(RegWdtStatus, data_t'(ws));
    expect_reg(RegHwErrFatal, data_t'(1) << NumHwErr);
    check_bit("all_error_fatal_o", all_error_fatal, 1'b1);
    write_reg(RegWdtCfg, '0);
    write_reg(RegWdtStatus, 32'h3);
    write_reg(RegHwErrFatal, FatalBits);

    // Pets keep timer 1 from expiring
    write_reg(RegWdtT2Period, 32'd1000);
    write_reg(RegWdtCfg, 32'h1);
    repeat (10) begin
      write_reg(RegWdtRestart, 32'h1);
      c0 = accept_cycle;
      wait_until(c0 + 10);
    end
    expect_reg(RegWdtStatus, '0);
    wait_until(c0 + 25);
    ws = exp_wdt_status(25, 20, 1000, 1'b1, WdtCascade);
    check_bit("wdt_t1_timeout_o", wdt_t1_timeout, ws[0]);
    write_reg(RegWdtStatus, 32'h1);
    c0 = accept_cycle;
    expect_reg(RegWdtStatus, '0);
    wait_until(c0 + 15);
    ws = exp_wdt_status(15, 20, 1000, 1'b1, WdtCascade);
    check_bit("wdt_t1_timeout_o", wdt_t1_timeout, ws[0]);
    wait_until(c0 + 25);
    ws = exp_wdt_status(25, 20, 1000, 1'b1, WdtCascade);
    check_bit("wdt_t1_timeout_o", wdt_t1_timeout, ws[0]);
    write_reg(RegWdtCfg, '0);
    write_reg(RegWdtStatus, 32'h3);

    // Independent mode
    write_reg(RegWdtT1Period, 32'd1000);
    write_reg(RegWdtT2Period, 32'd30);
    write_reg(RegWdtCfg, 32'h3);
    c0 = accept_cycle;
    wait_until(c0 + 40);
    ws = exp_wdt_status(40, 1000, 30, 1'b1, WdtIndependent);
    expect_reg(RegWdtStatus, data_t'(ws));
    check_bit("wdt_t1_timeout_o", wdt_t1_timeout, ws[0]);
    write_reg(RegWdtCfg, '0);
    write_reg(RegWdtStatus, 32'h3);
    write_reg(RegHwErrFatal, FatalBits);

    // Random error pulses under random masks
    for (int i = 0; i < 40; i++) begin
      if (i % 10 == 0) begin
        write_reg(RegHwErrFatalMask, $urandom() & FatalBits);
        write_reg(RegHwErrNonFatalMask, $urandom() & NonFatalBits);
      end
      @(posedge clk);
      hw_err_fatal     <= NumHwErr'($urandom());
      hw_err_non_fatal <= NumHwErr'($urandom());
      @(posedge clk);
      hw_err_fatal     <= '0;
      hw_err_non_fatal <= '0;
      wait_cycles(int'($urandom() % 4));
      if (i % 8 == 7) begin
        write_reg(RegHwErrFatal, FatalBits);
        write_reg(RegHwErrNonFatal, NonFatalBits);
      end
    end
    write_reg(RegHwErrFatalMask, '0);
    write_reg(RegHwErrNonFatalMask, '0);
    write_reg(RegHwErrFatal, FatalBits);
    write_reg(RegHwErrNonFatal, NonFatalBits);
    wait_cycles(3);
    check_bit("all_error_fatal_o", all_error_fatal, 1'b0);
    check_bit("all_error_non_fatal_o", all_error_non_fatal, 1'b0);

    // Fully masked sources stay quiet
    write_reg(RegHwErrFatalMask, FatalBits);
    write_reg(RegHwErrNonFatalMask, NonFatalBits);
    @(posedge clk);
    hw_err_fatal     <= '1;
    hw_err_non_fatal <= '1;
    @(posedge clk);
    hw_err_fatal     <= '0;
    hw_err_non_fatal <= '0;
    wait_cycles(4);
    check_bit("all_error_fatal_o", all_error_fatal, 1'b0);
    check_bit("all_error_non_fatal_o", all_error_non_fatal, 1'b0);
    write_reg(RegHwErrFatal, FatalBits);
    write_reg(RegHwErrNonFatal, NonFatalBits);

    // Firmware fatal code
    write_reg(RegFwErrFatal, $urandom() | 32'h1);
    wait_cycles(3);
    check_bit("all_error_fatal_o", all_error_fatal, 1'b1);
    write_reg(RegFwErrFatal, '0);
    wait_cycles(3);
    check_bit("all_error_fatal_o", all_error_fatal, 1'b0);

    wait_cycles(4);
    $display("Errors: %0d value mismatches, %0d protocol", val_errs, proto_errs);
    if (val_errs + proto_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+verif
src/mci_pkg.sv
src/mci_reg_if.sv
src/mci_axil_slave.sv
src/mci_wdt.sv
src/mci_error_agg.sv
src/mci_top.sv
verif/mci_tb_top.sv

/* Bender.yml */
package:
  name: mci

sources:
  - src/mci_pkg.sv
  - src/mci_reg_if.sv
  - src/mci_axil_slave.sv
  - src/mci_wdt.sv
  - src/mci_error_agg.sv
  - src/mci_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/mci_tb_top.sv
